//--- dv/ex_input_vectors.txt
# I dest npc ppc pht inst rega regb opa_sel opb_sel alu_func cond_br uncond_br rd_mem wr_mem
# M tag value / R dest value npc is_branch taken mispredict pht cpc / Q tag is_store addr value
I 01 1004 0 05 00000000 10 20 0 0 00 0 0 0 0
I 02 1008 0 00 0000fff0 0 4 1 0 01 0 0 0 0
I 03 100c 0 00 001fe000 0 0 2 1 02 0 0 0 0
I 04 1010 0 00 00000000 0 5 3 0 04 0 0 0 0
I 05 1014 0 00 00000010 0 0 2 2 00 0 0 0 0
I 06 1018 0 00 00000000 ff00 0ff0 0 0 06 0 0 0 0
I 07 101c 0 00 00000000 8000000000000000 4 0 0 0a 0 0 0 0
I 08 1020 0 00 00000000 ffffffffffffffff 1 0 0 0d 0 0 0 0
I 09 1024 0 00 0007e000 1 0 0 1 09 0 0 0 0
I 0a 2000 2010 3a e4000004 0 0 2 2 00 1 0 0 0
I 0b 3000 3020 7f f4000008 0 0 2 2 00 1 0 0 0
I 0c 4000 4000 11 e81ffffc 8000000000000000 0 2 2 00 1 0 0 0
I 0d 5000 5000 c3 f0000002 6 0 2 2 00 1 0 0 0
I 0e 5100 6004 22 00000000 0 6007 3 0 02 0 1 0 0
I 0f 7000 7000 44 fc000001 5 0 2 2 00 1 0 0 0
I 10 8000 0 00 00000000 3 5 0 0 0b 0 0 0 0
I 11 8004 0 00 00000000 123456789 1000 0 0 0b 0 0 0 0
I 12 8008 0 00 00000000 ffffffffffffffff 2 0 0 0b 0 0 0 0
I 13 800c 0 00 00000000 100000000 100000001 0 0 0b 0 0 0 0
M 15 aaaa
I 14 9000 0 00 00000000 1 1 0 0 00 0 0 0 0
M 16 bbbb
M 17 cccc
I 18 9004 0 00 00000000 7 7 0 0 0c 0 0 0 0
I 19 a000 0 00 a4000010 0 10000 1 0 00 0 0 1 0
I 1a a004 0 00 b400fff8 deadbeef 20000 1 0 00 0 0 0 1
M 19 1234567890abcdef
R 01 30 1004 0 0 0 05 1004
R 02 ffffffffffffffec 1008 0 0 0 00 1008
R 03 c 100c 0 0 0 00 100c
R 04 fffffffffffffffd 1010 0 0 0 00 1010
R 05 1054 1014 0 0 0 00 1014
R 06 f0f0 1018 0 0 0 00 1018
R 07 f800000000000000 101c 0 0 0 00 101c
R 08 1 1020 0 0 0 00 1020
R 09 8000000000000000 1024 0 0 0 00 1024
R 0a 2010 2000 1 1 0 3a 2010
R 0b 3020 3000 1 0 1 7f 3000
R 0c 3ff0 4000 1 1 1 11 3ff0
R 0d 5008 5000 1 0 0 c3 5000
R 0e 6004 5100 1 1 0 22 6004
R 0f 7004 7000 1 1 1 44 7004
R 10 f 8000 0 0 0 00 0
R 11 123456789000 8004 0 0 0 00 0
R 12 fffffffffffffffe 8008 0 0 0 00 0
R 13 100000000 800c 0 0 0 00 0
R 15 aaaa 0 0 0 0 00 0
R 14 2 9000 0 0 0 00 9000
R 16 bbbb 0 0 0 0 00 0
R 17 cccc 0 0 0 0 00 0
R 18 1 9004 0 0 0 00 9004
R 19 1234567890abcdef 0 0 0 0 00 0
Q 19 0 10010 0
Q 1a 1 1fff8 deadbeef

//--- sim.f
hdl/ex_pkg.sv
hdl/ex_decode.sv
hdl/ex_int_unit.sv
hdl/ex_mult.sv
hdl/ex_result_arbiter.sv
hdl/ex_stage.sv
dv/ex_tb_clock.sv
dv/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = ex_stage_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = All tests passed
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/ex_stage_tb.sv
// Testbench for the execute stage
// Reads issue, memory return and expected records from the vector file
// Drives issue and mem_ret, holding an instruction while stall is high
// Matches every result and LSQ request by tag, order independent
// Cycle limit, error counts and closing verdict
`timescale 1ns/100ps
`default_nettype none

module ex_stage_tb;

  localparam int    HIST_BITS   = ex_pkg::HIST_BITS_DEF;
  localparam int    MULT_STAGES = ex_pkg::MULT_STAGES_DEF;
  localparam string VEC_FILE    = "dv/ex_input_vectors.txt";

  // One driven step, either an issue or a memory return
  typedef struct packed {
    logic                is_mem;
    ex_pkg::ex_issue_t   iss;
    ex_pkg::ex_mem_ret_t mr;
  } step_t;

  logic                clock;
  logic                rst_n;
  ex_pkg::ex_issue_t   issue;
  ex_pkg::ex_mem_ret_t mem_ret;
  logic                stall;
  ex_pkg::ex_result_t  result;
  ex_pkg::ex_lsq_req_t lsq_req;

  step_t               steps   [$];
  ex_pkg::ex_result_t  exp_res [$];
  ex_pkg::ex_lsq_req_t exp_lsq [$];

  int n_records   = 0;
  int cycle_limit = 0;
  int cycles      = 0;
  int mismatches  = 0;
  int unexpected  = 0;
  int missing     = 0;

  ex_tb_clock #(
    .PERIOD_NS (4.0)
  ) i_ex_tb_clock (
    .clock (clock)
  );

  ex_stage #(
    .HIST_BITS   (HIST_BITS),
    .MULT_STAGES (MULT_STAGES)
  ) i_ex_stage (
    .clock   (clock),
    .rst_n   (rst_n),
    .issue   (issue),
    .mem_ret (mem_ret),
    .stall   (stall),
    .result  (result),
    .lsq_req (lsq_req)
  );

  //////////////////////////////////////////////////////////////////////
  // Vector file

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [63:0] f [14];
    step_t       st;
    ex_pkg::ex_result_t  r;
    ex_pkg::ex_lsq_req_t q;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open vector file %s", VEC_FILE);
      missing++;
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 1)
      begin
        kind = line.getc(0);
        line = line.substr(1, line.len() - 1);
        st = '0;
        r  = '0;
        q  = '0;
        if (kind == "I")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13]);
          st.iss.valid     = 1'b1;
          st.iss.dest_reg  = f[0][4:0];
          st.iss.npc       = f[1];
          st.iss.ppc       = f[2];
          st.iss.pht_idx   = f[3][HIST_BITS-1:0];
          st.iss.inst.raw  = f[4][31:0];
          st.iss.rega      = f[5];
          st.iss.regb      = f[6];
          st.iss.opa_sel   = ex_pkg::opa_sel_e'(f[7][1:0]);
          st.iss.opb_sel   = ex_pkg::opb_sel_e'(f[8][1:0]);
          st.iss.alu_func  = ex_pkg::alu_func_e'(f[9][4:0]);
          st.iss.cond_br   = f[10][0];
          st.iss.uncond_br = f[11][0];
          st.iss.rd_mem    = f[12][0];
          st.iss.wr_mem    = f[13][0];
          steps.push_back(st);
          n_records++;
        end
        else if (kind == "M")
        begin
          n = $sscanf(line, "%h %h", f[0], f[1]);
          st.is_mem   = 1'b1;
          st.mr.valid = 1'b1;
          st.mr.tag   = f[0][4:0];
          st.mr.value = f[1];
          steps.push_back(st);
          n_records++;
        end
        else if (kind == "R")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
          r.valid      = 1'b1;
          r.dest_reg   = f[0][4:0];
          r.value      = f[1];
          r.npc        = f[2];
          r.is_branch  = f[3][0];
          r.taken      = f[4][0];
          r.mispredict = f[5][0];
          r.pht_idx    = f[6][HIST_BITS-1:0];
          r.cpc        = f[7];
          exp_res.push_back(r);
          n_records++;
        end
        else if (kind == "Q")
        begin
          n = $sscanf(line, "%h %h %h %h", f[0], f[1], f[2], f[3]);
          q.valid    = 1'b1;
          q.tag      = f[0][4:0];
          q.is_store = f[1][0];
          q.addr     = f[2];
          q.value    = f[3];
          exp_lsq.push_back(q);
          n_records++;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // ALU or branch work, the only class that needs the result port
  function automatic logic wants_port(input ex_pkg::ex_issue_t iss);
    return iss.valid && !iss.rd_mem && !iss.wr_mem && iss.alu_func != ex_pkg::ALU_MULQ;
  endfunction

  task automatic match_result(input ex_pkg::ex_result_t got);
    int                 idx;
    ex_pkg::ex_result_t exp;
    idx = -1;
    foreach (exp_res[i])
    begin
      if (idx < 0 && exp_res[i].dest_reg == got.dest_reg)
        idx = i;
    end
    assert (idx >= 0)
    else
    begin
      $display("Result for dest_reg %0d at %0t matches no expected record",
               got.dest_reg, $time);
      unexpected++;
    end
    if (idx >= 0)
    begin
      exp = exp_res[idx];
      exp_res.delete(idx);
      check_field("result.value", got.value, exp.value);
      check_field("result.npc", got.npc, exp.npc);
      check_field("result.is_branch", 64'(got.is_branch), 64'(exp.is_branch));
      check_field("result.taken", 64'(got.taken), 64'(exp.taken));
      check_field("result.mispredict", 64'(got.mispredict), 64'(exp.mispredict));
      check_field("result.pht_idx", 64'(got.pht_idx), 64'(exp.pht_idx));
      check_field("result.cpc", got.cpc, exp.cpc);
    end
  endtask

  task automatic match_lsq(input ex_pkg::ex_lsq_req_t got);
    int                  idx;
    ex_pkg::ex_lsq_req_t exp;
    idx = -1;
    foreach (exp_lsq[i])
    begin
      if (idx < 0 && exp_lsq[i].tag == got.tag)
        idx = i;
    end
    assert (idx >= 0)
    else
    begin
      $display("LSQ request for tag %0d at %0t matches no expected record", got.tag, $time);
      unexpected++;
    end
    if (idx >= 0)
    begin
      exp = exp_lsq[idx];
      exp_lsq.delete(idx);
      check_field("lsq_req.is_store", 64'(got.is_store), 64'(exp.is_store));
      check_field("lsq_req.addr", got.addr, exp.addr);
      check_field("lsq_req.value", got.value, exp.value);
    end
  endtask

  // Outputs are sampled half a cycle away from the driving edge
  always @(negedge clock)
  begin
    if (rst_n)
    begin
      if (result.valid)
        match_result(result);
      if (lsq_req.valid)
        match_lsq(lsq_req);
      if (mem_ret.valid && wants_port(issue))
        check_field("stall", 64'(stall), 64'd1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic drive_step();
    mem_ret <= '0;
    if (steps.size() > 0 && steps[0].is_mem)
    begin
      mem_ret <= steps[0].mr;
      void'(steps.pop_front());
    end
    if (!(issue.valid && stall))          // Held instruction stays put
    begin
      if (steps.size() > 0 && !steps[0].is_mem)
      begin
        issue <= steps[0].iss;
        void'(steps.pop_front());
      end
      else
        issue <= '0;
    end
  endtask

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("Run stopped at the cycle limit of %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial
  begin
    int drain;
    rst_n   = 1'b0;
    issue   = '0;
    mem_ret = '0;
    load_vectors();
    cycle_limit = n_records * (MULT_STAGES + 4) + 50;

    // Live load and memory return during reset, neither may reach the outputs
    @(posedge clock);
    issue.valid    <= 1'b1;
    issue.rd_mem   <= 1'b1;
    issue.dest_reg <= 5'h1f;
    mem_ret.valid  <= 1'b1;
    mem_ret.tag    <= 5'h1e;
    repeat (3) @(posedge clock);
    rst_n   <= 1'b1;
    issue   <= '0;
    mem_ret <= '0;
    @(negedge clock);
    check_field("result.valid", 64'(result.valid), 64'd0);
    check_field("lsq_req.valid", 64'(lsq_req.valid), 64'd0);
    check_field("stall", 64'(stall), 64'd0);

    do
    begin
      @(posedge clock);
      drive_step();
      @(negedge clock);
    end
    while (steps.size() > 0 || issue.valid || mem_ret.valid);

    // Let the multiplier and registered outputs drain
    drain = 0;
    while (exp_res.size() + exp_lsq.size() > 0 && drain < 4 * (MULT_STAGES + 4))
    begin
      @(negedge clock);
      drain++;
    end
    repeat (2) @(negedge clock);

    foreach (exp_res[i])
    begin
      $display("Expected result for dest_reg %0d never arrived", exp_res[i].dest_reg);
      missing++;
    end
    foreach (exp_lsq[i])
    begin
      $display("Expected LSQ request for tag %0d never arrived", exp_lsq[i].tag);
      missing++;
    end

    $display("Errors: %0d mismatched, %0d unexpected, %0d missing",
             mismatches, unexpected, missing);
    if (mismatches + unexpected + missing == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/ex_tb_clock.sv
// Free-running clock for the execute stage testbench
// Period set by parameter, starts low
`timescale 1ns/100ps
`default_nettype none

module ex_tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clock
);

  initial
  begin
    clock = 1'b0;
    forever
      #(PERIOD_NS / 2.0) clock = ~clock;
  end

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
// Execute stage top level
// Decode, integer and branch unit, multiplier and writeback arbiter
`timescale 1ns/100ps
`default_nettype none

module ex_stage #(
  parameter int HIST_BITS   = ex_pkg::HIST_BITS_DEF,
  parameter int MULT_STAGES = ex_pkg::MULT_STAGES_DEF
) (
  input  wire                      clock,
  input  wire                      rst_n,
  input  wire ex_pkg::ex_issue_t   issue,
  input  wire ex_pkg::ex_mem_ret_t mem_ret,
  output logic                     stall,
  output ex_pkg::ex_result_t       result,
  output ex_pkg::ex_lsq_req_t      lsq_req
);

  ex_pkg::xlen_t opa;
  ex_pkg::xlen_t opb;
  logic          mult_go;
  logic          needs_port;
  logic          lsq_go;

  ex_pkg::xlen_t alu_out;
  logic          taken;
  logic          mispredict;
  ex_pkg::xlen_t cpc;

  logic          mult_done;
  logic [4:0]    mult_tag;
  ex_pkg::xlen_t mult_npc;
  ex_pkg::xlen_t mult_product;
  logic          mult_hold;   // Arbiter freezes the multiplier

  ex_decode i_ex_decode (
    .issue      (issue),
    .stall      (stall),
    .opa        (opa),
    .opb        (opb),
    .mult_go    (mult_go),
    .needs_port (needs_port),
    .lsq_go     (lsq_go)
  );

  ex_int_unit #(
    .HIST_BITS (HIST_BITS)
  ) i_ex_int_unit (
    .opa        (opa),
    .opb        (opb),
    .issue      (issue),
    .alu_out    (alu_out),
    .taken      (taken),
    .mispredict (mispredict),
    .cpc        (cpc)
  );

  ex_mult #(
    .MULT_STAGES (MULT_STAGES)
  ) i_ex_mult (
    .clock    (clock),
    .rst_n    (rst_n),
    .go       (mult_go),
    .mcand    (opa),
    .mplier   (opb),
    .tag      (issue.dest_reg),
    .npc      (issue.npc),
    .hold     (mult_hold),
    .done     (mult_done),
    .done_tag (mult_tag),
    .done_npc (mult_npc),
    .product  (mult_product)
  );

  ex_result_arbiter i_ex_result_arbiter (
    .clock        (clock),
    .rst_n        (rst_n),
    .mem_ret      (mem_ret),
    .mult_done    (mult_done),
    .mult_tag     (mult_tag),
    .mult_npc     (mult_npc),
    .mult_product (mult_product),
    .alu_out      (alu_out),
    .taken        (taken),
    .mispredict   (mispredict),
    .cpc          (cpc),
    .issue        (issue),
    .needs_port   (needs_port),
    .lsq_go       (lsq_go),
    .mult_go      (mult_go),
    .stall        (stall),
    .mult_hold    (mult_hold),
    .result       (result),
    .lsq_req      (lsq_req)
  );

endmodule

`default_nettype wire

//--- hdl/ex_result_arbiter.sv
// Writeback arbiter for the execute stage
// Fixed priority: memory return, multiplier, ALU or branch
// Stall to decode and hold to the multiplier
// Registered result bus and LSQ request
`timescale 1ns/100ps
`default_nettype none

module ex_result_arbiter (
  input  wire                      clock,
  input  wire                      rst_n,
  input  wire ex_pkg::ex_mem_ret_t mem_ret,
  input  wire                      mult_done,
  input  wire [4:0]                mult_tag,
  input  wire ex_pkg::xlen_t       mult_npc,
  input  wire ex_pkg::xlen_t       mult_product,
  input  wire ex_pkg::xlen_t       alu_out,
  input  wire                      taken,
  input  wire                      mispredict,
  input  wire ex_pkg::xlen_t       cpc,
  input  wire ex_pkg::ex_issue_t   issue,
  input  wire                      needs_port,
  input  wire                      lsq_go,
  input  wire                      mult_go,
  output logic                     stall,
  output logic                     mult_hold,
  output ex_pkg::ex_result_t       result,
  output ex_pkg::ex_lsq_req_t      lsq_req
);

  logic                port_busy;   // A higher-priority source wants the bus
  logic                mult_req;    // mulq sitting on issue
  logic                alu_take;
  logic                is_branch;
  ex_pkg::ex_result_t  res_nxt;
  ex_pkg::ex_lsq_req_t lsq_nxt;

  //////////////////////////////////////////////////////////////////////
  // Back-pressure

  assign port_busy = mem_ret.valid | mult_done;
  assign mult_hold = mem_ret.valid & mult_done;   // Memory return wins the bus
  assign mult_req  = issue.valid && issue.alu_func == ex_pkg::ALU_MULQ
                     && !(issue.rd_mem || issue.wr_mem);

  assign stall    = (needs_port & port_busy) | (mult_req & mult_hold);
  assign alu_take = needs_port & ~stall;
  assign is_branch = issue.cond_br | issue.uncond_br;

  //////////////////////////////////////////////////////////////////////
  // Next writeback

  always_comb
  begin
    res_nxt = '0;
    if (mem_ret.valid)
    begin
      res_nxt.valid    = 1'b1;
      res_nxt.dest_reg = mem_ret.tag;   // Load dest_reg came back as the tag
      res_nxt.value    = mem_ret.value;
    end
    else if (mult_done)
    begin
      res_nxt.valid    = 1'b1;
      res_nxt.dest_reg = mult_tag;
      res_nxt.npc      = mult_npc;
      res_nxt.value    = mult_product;
    end
    else if (alu_take)
    begin
      res_nxt.valid      = 1'b1;
      res_nxt.dest_reg   = issue.dest_reg;
      res_nxt.npc        = issue.npc;
      res_nxt.value      = alu_out;
      res_nxt.is_branch  = is_branch;
      res_nxt.taken      = is_branch & taken;
      res_nxt.mispredict = is_branch & mispredict;
      res_nxt.pht_idx    = issue.pht_idx;
      res_nxt.cpc        = cpc;
    end
  end

  // Store data is register A, the address is base plus displacement
  assign lsq_nxt = '{valid:    lsq_go,
                     is_store: issue.wr_mem,
                     tag:      issue.dest_reg,
                     addr:     alu_out,
                     value:    issue.rega};

  always_ff @(posedge clock)
  begin
    result  <= res_nxt;
    lsq_req <= lsq_nxt;
    if (!rst_n)
    begin
      result.valid  <= 1'b0;
      lsq_req.valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  // A held product is not a second writer, it waits a cycle
  a_one_source : assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({mem_ret.valid, mult_done & ~mult_hold, alu_take}));

  // Decode steers each accepted instruction down one path only
  a_one_path : assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({alu_take, mult_go, lsq_go}));

endmodule

`default_nettype wire

//--- hdl/ex_mult.sv
// Pipelined 64-bit multiplier, low half of the product
// One partial-product chunk of the multiplier per stage
// Tag and NPC carried alongside each stage
// Whole pipeline freezes on hold
`timescale 1ns/100ps
`default_nettype none

module ex_mult #(
  parameter int MULT_STAGES = ex_pkg::MULT_STAGES_DEF
) (
  input  wire                clock,
  input  wire                rst_n,
  input  wire                go,
  input  wire ex_pkg::xlen_t mcand,
  input  wire ex_pkg::xlen_t mplier,
  input  wire [4:0]          tag,
  input  wire ex_pkg::xlen_t npc,
  input  wire                hold,
  output logic               done,
  output logic [4:0]         done_tag,
  output ex_pkg::xlen_t      done_npc,
  output ex_pkg::xlen_t      product
);

  localparam int CHUNK = 64 / MULT_STAGES;   // Multiplier bits per stage

  typedef struct packed {
    logic [4:0]    tag;
    ex_pkg::xlen_t npc;
    ex_pkg::xlen_t acc;   // Running sum of partial products
    ex_pkg::xlen_t mc;    // Multiplicand, moved up one chunk per stage
    ex_pkg::xlen_t mp;    // Multiplier bits still to use
  } stage_t;

  logic [MULT_STAGES-1:0] vld;
  stage_t                 pipe      [MULT_STAGES];
  stage_t                 stage_in  [MULT_STAGES];
  stage_t                 stage_nxt [MULT_STAGES];

  always_comb
  begin
    stage_in[0] = '{tag: tag, npc: npc, acc: '0, mc: mcand, mp: mplier};
    for (int s = 1; s < MULT_STAGES; s++)
      stage_in[s] = pipe[s-1];
    for (int s = 0; s < MULT_STAGES; s++)
    begin
      stage_nxt[s]     = stage_in[s];
      stage_nxt[s].acc = stage_in[s].acc
                         + stage_in[s].mc * ex_pkg::xlen_t'(stage_in[s].mp[CHUNK-1:0]);
      stage_nxt[s].mc  = stage_in[s].mc << CHUNK;
      stage_nxt[s].mp  = stage_in[s].mp >> CHUNK;
    end
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      vld <= '0;
    else if (!hold)
      vld <= MULT_STAGES'({vld, go});   // Shift valids toward the last stage
  end

  always_ff @(posedge clock)
  begin
    if (!hold)
      pipe <= stage_nxt;
  end

  assign done     = vld[MULT_STAGES-1];
  assign done_tag = pipe[MULT_STAGES-1].tag;
  assign done_npc = pipe[MULT_STAGES-1].npc;
  assign product  = pipe[MULT_STAGES-1].acc;

  // Decode stalls a mulq while frozen, otherwise it would be dropped
  a_no_go_on_hold : assert property (@(posedge clock) disable iff (!rst_n)
    hold |-> !go);

endmodule

`default_nettype wire

//--- hdl/ex_int_unit.sv
// Integer and branch unit
// 64-bit ALU over the operate functions
// Branch condition test on register A
// Taken, correct next PC and mispredict flag
`timescale 1ns/100ps
`default_nettype none

module ex_int_unit #(
  parameter int HIST_BITS = ex_pkg::HIST_BITS_DEF
) (
  input  wire ex_pkg::xlen_t     opa,
  input  wire ex_pkg::xlen_t     opb,
  input  wire ex_pkg::ex_issue_t issue,
  output ex_pkg::xlen_t          alu_out,
  output logic                   taken,
  output logic                   mispredict,
  output ex_pkg::xlen_t          cpc
);

  logic brcond;

  // History width is fixed by the shared bus types
  if (HIST_BITS != $bits(ex_pkg::pht_idx_t))
  begin : g_hist_check
    $error("ex_int_unit: HIST_BITS does not match pht_idx width");
  end

  //////////////////////////////////////////////////////////////////////
  // ALU

  always_comb
  begin
    case (issue.alu_func)
      ex_pkg::ALU_ADDQ:   alu_out = opa + opb;
      ex_pkg::ALU_SUBQ:   alu_out = opa - opb;
      ex_pkg::ALU_AND:    alu_out = opa & opb;
      ex_pkg::ALU_BIC:    alu_out = opa & ~opb;
      ex_pkg::ALU_BIS:    alu_out = opa | opb;
      ex_pkg::ALU_ORNOT:  alu_out = opa | ~opb;
      ex_pkg::ALU_XOR:    alu_out = opa ^ opb;
      ex_pkg::ALU_EQV:    alu_out = opa ^ ~opb;
      ex_pkg::ALU_SRL:    alu_out = opa >> opb[5:0];
      ex_pkg::ALU_SLL:    alu_out = opa << opb[5:0];
      ex_pkg::ALU_SRA:    alu_out = $signed(opa) >>> opb[5:0];
      ex_pkg::ALU_CMPEQ:  alu_out = {63'b0, opa == opb};
      ex_pkg::ALU_CMPLT:  alu_out = {63'b0, $signed(opa) < $signed(opb)};
      ex_pkg::ALU_CMPLE:  alu_out = {63'b0, $signed(opa) <= $signed(opb)};
      ex_pkg::ALU_CMPULT: alu_out = {63'b0, opa < opb};
      ex_pkg::ALU_CMPULE: alu_out = {63'b0, opa <= opb};
      default:            alu_out = '0;   // mulq runs in the multiplier
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Branch resolve

  always_comb
  begin
    case (issue.inst.br.opcode[2:0])
      3'b000: brcond = ~issue.rega[0];                  // Low bit clear
      3'b001: brcond = issue.rega == '0;                // eq
      3'b010: brcond = issue.rega[63];                  // lt
      3'b011: brcond = issue.rega[63] || issue.rega == '0;
      3'b100: brcond = issue.rega[0];                   // Low bit set
      3'b101: brcond = issue.rega != '0;                // ne
      3'b110: brcond = ~issue.rega[63];                 // ge
      default: brcond = ~issue.rega[63] && issue.rega != '0;  // gt
    endcase
  end

  assign taken      = issue.uncond_br | (issue.cond_br & brcond);
  assign cpc        = taken ? alu_out : issue.npc;   // ALU computes the target
  assign mispredict = cpc != issue.ppc;

endmodule

`default_nettype wire

//--- hdl/ex_decode.sv
// Operand build for the execute stage
// Immediates from the instruction union views
// Operand A and B select muxes
// Steering to the ALU port, the multiplier or the LSQ
`timescale 1ns/100ps
`default_nettype none

module ex_decode (
  input  wire ex_pkg::ex_issue_t issue,
  input  wire                    stall,
  output ex_pkg::xlen_t          opa,
  output ex_pkg::xlen_t          opb,
  output logic                   mult_go,
  output logic                   needs_port,
  output logic                   lsq_go
);

  localparam ex_pkg::xlen_t OPB_BAD = 64'hbad0_0b5e_1ec7_0bad;  // Shows up on a bad select

  ex_pkg::xlen_t mem_disp;
  ex_pkg::xlen_t br_disp;
  ex_pkg::xlen_t alu_imm;
  logic          is_mem;
  logic          is_mult;

  //////////////////////////////////////////////////////////////////////
  // Immediates

  assign mem_disp = {{48{issue.inst.mem.disp[15]}}, issue.inst.mem.disp};
  assign br_disp  = {{41{issue.inst.br.disp[20]}}, issue.inst.br.disp, 2'b00};  // Times 4
  assign alu_imm  = {56'b0, issue.inst.op.src_b.lit};                          // Zero extended

  //////////////////////////////////////////////////////////////////////
  // Operand muxes

  always_comb
  begin
    case (issue.opa_sel)
      ex_pkg::OPA_REGA:     opa = issue.rega;
      ex_pkg::OPA_MEM_DISP: opa = mem_disp;
      ex_pkg::OPA_NPC:      opa = issue.npc;
      default:              opa = ~64'h3;   // Alignment mask for jumps
    endcase
  end

  always_comb
  begin
    case (issue.opb_sel)
      ex_pkg::OPB_REGB:    opb = issue.regb;
      ex_pkg::OPB_ALU_IMM: opb = alu_imm;
      ex_pkg::OPB_BR_DISP: opb = br_disp;
      default:             opb = OPB_BAD;
    endcase
  end

  // Upstream decode must never send the unused select with a live instruction
  always_comb
  begin
    if (issue.valid)
    begin
      a_opb_sel : assert #0 (issue.opb_sel != 2'h3)
        else $error("ex_decode: invalid opb select on a valid issue");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Steering

  assign is_mem  = issue.rd_mem | issue.wr_mem;
  assign is_mult = (issue.alu_func == ex_pkg::ALU_MULQ) && !is_mem;

  // Request level, the arbiter builds stall from it
  assign needs_port = issue.valid & ~is_mem & ~is_mult;

  assign mult_go = issue.valid & is_mult & ~stall;
  assign lsq_go  = issue.valid & is_mem & ~stall;   // Address comes from the ALU

endmodule

`default_nettype wire

//--- hdl/ex_pkg.sv
// Shared types for the execute stage
// Parameter defaults for history width and multiplier depth
// Instruction word as a packed union of memory, operate and branch views
// ALU function and operand select encodings
// Issue, writeback, memory return and LSQ request structs
`default_nettype none

package ex_pkg;

  localparam int HIST_BITS_DEF   = 8;
  localparam int MULT_STAGES_DEF = 4;

  typedef logic [63:0]              xlen_t;
  typedef logic [4:0]               reg_idx_t;
  typedef logic [HIST_BITS_DEF-1:0] pht_idx_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction formats

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    ra;
    reg_idx_t    rb;
    logic [15:0] disp;       // Sign extended by decode
  } mem_fmt_t;

  // Operand B field is a register or an 8-bit literal, picked by lit_flag
  typedef union packed {
    struct packed {
      reg_idx_t   rb;
      logic [2:0] sbz;
    } r;
    logic [7:0] lit;
  } op_src_b_u;

  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   ra;
    op_src_b_u  src_b;
    logic       lit_flag;
    logic [6:0] func;
    reg_idx_t   rc;
  } op_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;     // Bits 28:26 give the branch condition
    reg_idx_t    ra;
    logic [20:0] disp;       // Longword displacement
  } br_fmt_t;

  typedef union packed {
    mem_fmt_t    mem;
    op_fmt_t     op;
    br_fmt_t     br;
    logic [31:0] raw;
  } ex_inst_u;

  //////////////////////////////////////////////////////////////////////
  // Encodings

  typedef enum logic [4:0] {
    ALU_ADDQ  = 5'h00,
    ALU_SUBQ  = 5'h01,
    ALU_AND   = 5'h02,
    ALU_BIC   = 5'h03,
    ALU_BIS   = 5'h04,
    ALU_ORNOT = 5'h05,
    ALU_XOR   = 5'h06,
    ALU_EQV   = 5'h07,
    ALU_SRL   = 5'h08,
    ALU_SLL   = 5'h09,
    ALU_SRA   = 5'h0a,
    ALU_MULQ  = 5'h0b,
    ALU_CMPEQ = 5'h0c,
    ALU_CMPLT = 5'h0d,
    ALU_CMPLE = 5'h0e,
    ALU_CMPULT = 5'h0f,
    ALU_CMPULE = 5'h10
  } alu_func_e;

  typedef enum logic [1:0] {
    OPA_REGA     = 2'h0,
    OPA_MEM_DISP = 2'h1,
    OPA_NPC      = 2'h2,
    OPA_NOT3     = 2'h3
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_REGB    = 2'h0,
    OPB_ALU_IMM = 2'h1,
    OPB_BR_DISP = 2'h2
  } opb_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Buses in and out of the stage

  typedef struct packed {
    logic      valid;
    xlen_t     npc;
    xlen_t     ppc;          // Predicted next PC
    pht_idx_t  pht_idx;
    ex_inst_u  inst;
    reg_idx_t  dest_reg;
    xlen_t     rega;
    xlen_t     regb;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e alu_func;
    logic      cond_br;
    logic      uncond_br;
    logic      rd_mem;
    logic      wr_mem;
  } ex_issue_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dest_reg;
    xlen_t    npc;
    xlen_t    value;
    logic     is_branch;
    logic     taken;
    logic     mispredict;
    pht_idx_t pht_idx;
    xlen_t    cpc;           // Resolved next PC
  } ex_result_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t tag;
    xlen_t    value;
  } ex_mem_ret_t;

  typedef struct packed {
    logic     valid;
    logic     is_store;
    reg_idx_t tag;
    xlen_t    addr;
    xlen_t    value;
  } ex_lsq_req_t;

endpackage

`default_nettype wire
